/* filelist.f */
+incdir+logic
logic/div_pkg.sv
logic/div_bus_decode.sv
logic/div_unsigned_core.sv
logic/div_sign_fixup.sv
logic/div_unit_top.sv
sim/div_unit_assertions.sv
sim/div_unit_tb.sv

/* Makefile */
# Verilator build and run for the divide unit testbench.
VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := logic/div_config.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* sim/div_unit_tb.sv */
`timescale 1ns/1ps
`include "div_config.svh"

module div_unit_tb;

	localparam int TEST_CASES = 410; // Divisions plus register cases.
	localparam int TIMEOUT_CYCLES = TEST_CASES * 60;

	logic                   clk;
	logic                   rst_n;
	div_pkg::wb_m2s_s       bus_in;
	div_pkg::wb_s2m_s       bus_out;
	div_pkg::word_t         exp_q[$]; // Pending comparisons.
	div_pkg::word_t         act_q[$];
	string                  name_q[$];
	div_pkg::word_t         a; // Operands.
	div_pkg::word_t         b;
	div_pkg::word_t         rd; // Read data.
	logic [2*`DIV_XLEN-1:0] exp_pair; // Reference quotient and remainder.
	int                     cycles = 0;
	int                     checks = 0;
	int                     errors = 0;
	int                     test_errors = 0;

	div_unit_top uut (.clk(clk), .rst_n(rst_n), .bus_in(bus_in), .bus_out(bus_out));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Reference model, RISC-V M rules
	// ------------------------------------------------------------------
	function automatic logic [2*`DIV_XLEN-1:0] ref_div(input div_pkg::div_op_e op,
		input div_pkg::word_t x, input div_pkg::word_t y);
		logic           signed_op;
		div_pkg::word_t q;
		div_pkg::word_t r;
		signed_op = (op == div_pkg::DIV) || (op == div_pkg::REM);
		if (y == '0) begin
			q = '1; // All ones.
			r = x;
		end else if (signed_op && x == {1'b1, {(`DIV_XLEN-1){1'b0}}} && y == '1) begin
			q = x; // Overflow case.
			r = '0;
		end else if (signed_op) begin
			q = $signed(x) / $signed(y); // Truncates toward zero.
			r = $signed(x) % $signed(y);
		end else begin
			q = x / y;
			r = x % y;
		end
		return {q, r};
	endfunction

	task automatic check(input string name, input div_pkg::word_t exp, input div_pkg::word_t act);
		checks++;
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	// Comparison process.
	always @(posedge clk) begin
		while (act_q.size() > 0)
			check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic expect_word(input string name, input div_pkg::word_t exp,
		input div_pkg::word_t act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	task automatic end_test(input string name);
		while (act_q.size() != 0)
			@(negedge clk);
		$display("TEST %-12s %0d mismatches", name, test_errors);
		test_errors = 0;
	endtask

	// ------------------------------------------------------------------
	// Wishbone master tasks
	// ------------------------------------------------------------------
	task automatic bus_write(input div_pkg::wb_adr_t adr, input div_pkg::word_t dat);
		@(negedge clk);
		bus_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		do @(negedge clk); while (!bus_out.ack); // Wait states allowed.
		bus_in = '0;
	endtask

	task automatic bus_read(input div_pkg::wb_adr_t adr, output div_pkg::word_t dat);
		@(negedge clk);
		bus_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
		do @(negedge clk); while (!bus_out.ack);
		dat = bus_out.dat;
		bus_in = '0;
	endtask

	// Full division through the bus; the quotient read stalls while busy.
	task automatic run_div(input string name, input div_pkg::div_op_e op,
		input div_pkg::word_t x, input div_pkg::word_t y);
		logic [2*`DIV_XLEN-1:0] exp;
		div_pkg::word_t         q;
		div_pkg::word_t         r;
		exp = ref_div(op, x, y);
		bus_write(`DIV_REG_DIVIDEND, x);
		bus_write(`DIV_REG_DIVISOR, y);
		bus_write(`DIV_REG_CTRL, `DIV_XLEN'(op));
		bus_read(`DIV_REG_QUOT, q);
		bus_read(`DIV_REG_REM, r);
		expect_word($sformatf("%s %h/%h quotient", name, x, y), exp[2*`DIV_XLEN-1:`DIV_XLEN], q);
		expect_word($sformatf("%s %h/%h remainder", name, x, y), exp[`DIV_XLEN-1:0], r);
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	initial begin
		bus_in = '0;
		rst_n = 1'b0;
		void'($urandom(32'hedc4ed6f));
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		bus_read(`DIV_REG_CTRL, rd); // Idle status.
		expect_word("status after reset", '0, rd);
		a = $urandom;
		b = $urandom;
		bus_write(`DIV_REG_DIVIDEND, a);
		bus_write(`DIV_REG_DIVISOR, b);
		bus_read(`DIV_REG_DIVIDEND, rd);
		expect_word("dividend readback", a, rd);
		bus_read(`DIV_REG_DIVISOR, rd);
		expect_word("divisor readback", b, rd);
		end_test("readback");

		repeat (200) begin
			a = $urandom;
			b = $urandom >> ($urandom % 32); // Spread of quotient sizes.
			run_div("divu", div_pkg::DIVU, a, b);
		end
		end_test("unsigned");

		repeat (200) begin
			a = $urandom;
			b = $urandom >> ($urandom % 32);
			b = ($urandom % 2) ? -b : b;
			run_div("div", div_pkg::DIV, a, b);
		end
		run_div("div ++", div_pkg::DIV, 32'd7, 32'd2);
		run_div("div -+", div_pkg::DIV, -32'd7, 32'd2);
		run_div("div +-", div_pkg::DIV, 32'd7, -32'd2);
		run_div("div --", div_pkg::DIV, -32'd7, -32'd2);
		end_test("signed");

		run_div("divu by zero", div_pkg::DIVU, 32'h1234_5678, '0);
		bus_read(`DIV_REG_CTRL, rd);
		expect_word("status divu by zero", 32'h2, rd); // By-zero bit, op 0.
		run_div("rem by zero", div_pkg::REM, 32'h8765_4321, '0);
		bus_read(`DIV_REG_CTRL, rd);
		expect_word("status rem by zero", 32'he, rd);
		run_div("overflow", div_pkg::DIV, 32'h8000_0000, 32'hffff_ffff);
		bus_read(`DIV_REG_CTRL, rd);
		expect_word("status overflow", 32'h4, rd); // No by-zero flag.
		end_test("corner");

		a = -32'd7;
		b = 32'd2;
		run_div("stall read", div_pkg::DIVU, a, b);
		bus_write(`DIV_REG_CTRL, `DIV_XLEN'(div_pkg::DIV));
		bus_write(`DIV_REG_CTRL, `DIV_XLEN'(div_pkg::REMU)); // Written while busy.
		bus_read(`DIV_REG_QUOT, rd);
		exp_pair = ref_div(div_pkg::REMU, a, b);
		expect_word("second start quotient", exp_pair[2*`DIV_XLEN-1:`DIV_XLEN], rd);
		bus_read(`DIV_REG_CTRL, rd);
		expect_word("second start status", 32'h8, rd);
		end_test("backpressure");

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* sim/div_unit_assertions.sv */
`timescale 1ns/1ps

module div_unit_assertions (
	input logic             clk,
	input logic             rst_n,
	input div_pkg::wb_m2s_s bus_in,
	input div_pkg::wb_s2m_s bus_out,
	input logic             start,
	input logic             done
);

	logic       pending; // Core operation in flight.
	logic [5:0] wait_cnt; // Cycles since start.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
			wait_cnt <= '0;
		end else if (start) begin
			pending <= 1'b1;
			wait_cnt <= '0;
		end else if (done) begin
			pending <= 1'b0;
		end else if (pending) begin
			wait_cnt <= wait_cnt + 6'd1;
		end
	end

	// ------------------------------------------------------------------
	// Handshake and core timing
	// ------------------------------------------------------------------
	ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		bus_out.ack |=> !bus_out.ack)
		else $error("ack held high for two cycles");

	ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		bus_out.ack |-> $past(bus_in.cyc && bus_in.stb))
		else $error("ack raised without an open bus cycle");

	done_in_time: assert property (@(posedge clk) disable iff (!rst_n)
		pending |-> wait_cnt < 6'd34)
		else $error("core done missing 34 cycles after start");

endmodule

// Bus checks on the decoder, timing checks on the core.
bind div_bus_decode div_unit_assertions u_bus_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.bus_in  (bus_in),
	.bus_out (bus_out),
	.start   (1'b0),
	.done    (1'b0)
);

bind div_unsigned_core div_unit_assertions u_core_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.bus_in  ('0),
	.bus_out ('0),
	.start   (start),
	.done    (done)
);

/* logic/div_unit_top.sv */
`timescale 1ns/1ps

module div_unit_top (
	input  logic             clk,
	input  logic             rst_n,
	input  div_pkg::wb_m2s_s bus_in,
	output div_pkg::wb_s2m_s bus_out
);

	// ------------------------------------------------------------------
	// Internal connections
	// ------------------------------------------------------------------
	logic              start; // Decode to core.
	div_pkg::div_req_s req;
	logic              done; // Core to fixup.
	div_pkg::div_rsp_s rsp;
	logic              result_valid; // Fixup to decode.
	div_pkg::word_t    quotient;
	div_pkg::word_t    remainder;
	logic              by_zero;

	div_bus_decode u_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.bus_in       (bus_in),
		.bus_out      (bus_out),
		.result_valid (result_valid),
		.quotient     (quotient),
		.remainder    (remainder),
		.by_zero      (by_zero),
		.start        (start),
		.req          (req)
	);

	div_unsigned_core u_core (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.req   (req),
		.done  (done),
		.rsp   (rsp)
	);

	// Request stays stable until done, so fixup reads it directly.
	div_sign_fixup u_fixup (
		.clk          (clk),
		.rst_n        (rst_n),
		.done         (done),
		.rsp          (rsp),
		.req          (req),
		.result_valid (result_valid),
		.quotient     (quotient),
		.remainder    (remainder),
		.by_zero      (by_zero)
	);

endmodule

/* logic/div_sign_fixup.sv */
`timescale 1ns/1ps

module div_sign_fixup (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              done,
	input  div_pkg::div_rsp_s rsp,
	input  div_pkg::div_req_s req,
	output logic              result_valid,
	output div_pkg::word_t    quotient,
	output div_pkg::word_t    remainder,
	output logic              by_zero
);

	div_pkg::word_t quot_fix;
	div_pkg::word_t rem_fix;

	// ------------------------------------------------------------------
	// Sign and corner cases
	// ------------------------------------------------------------------
	always_comb begin
		quot_fix = req.neg_quot ? -rsp.quotient : rsp.quotient;
		rem_fix = req.neg_rem ? -rsp.remainder : rsp.remainder;
		if (rsp.by_zero) begin
			quot_fix = '1; // All ones on divide by zero.
			rem_fix = req.dividend; // Dividend passes through.
		end
	end

	// Result registers, loaded in the done cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			quotient <= '0;
			remainder <= '0;
			by_zero <= 1'b0;
		end else begin
			result_valid <= done; // One cycle after done.
			if (done) begin
				quotient <= quot_fix;
				remainder <= rem_fix;
				by_zero <= rsp.by_zero;
			end
		end
	end

endmodule

/* logic/div_unsigned_core.sv */
`timescale 1ns/1ps
`include "div_config.svh"

module div_unsigned_core (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  div_pkg::div_req_s req,
	output logic              done,
	output div_pkg::div_rsp_s rsp
);

	localparam int CNT_W = $clog2(`DIV_XLEN + 1); // Counts 0 to XLEN.

	div_pkg::core_state_e state;
	logic [CNT_W-1:0]     count;
	div_pkg::word_t       dividend_sr; // Bits still to shift in.
	div_pkg::word_t       quot_sr;
	logic [`DIV_XLEN:0]   part_rem; // One extra bit for the shifted value.
	logic [`DIV_XLEN:0]   divisor_ext;
	logic [`DIV_XLEN:0]   diff;
	logic [`DIV_XLEN:0]   rem_sel; // Partial remainder after this step.
	logic                 ge; // Remainder at least divisor.
	logic                 by_zero_q;

	assign divisor_ext = {1'b0, req.divisor_mag};
	assign diff = part_rem - divisor_ext;
	assign ge = part_rem >= divisor_ext;
	assign rem_sel = ge ? diff : part_rem; // Restore on a negative step.

	// ------------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= div_pkg::CORE_IDLE;
			done <= 1'b0;
			by_zero_q <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				div_pkg::CORE_IDLE: begin
					if (start) begin
						by_zero_q <= (req.divisor_mag == '0);
						if (req.divisor_mag == '0)
							done <= 1'b1; // Fixup supplies the result.
						else
							state <= div_pkg::CORE_SHIFT;
					end
				end
				div_pkg::CORE_SHIFT: begin
					if (count == CNT_W'(`DIV_XLEN)) begin
						done <= 1'b1; // Last compare done.
						state <= div_pkg::CORE_IDLE;
					end
				end
				default: state <= div_pkg::CORE_IDLE;
			endcase
		end
	end

	// Datapath.
	always_ff @(posedge clk) begin
		if (state == div_pkg::CORE_IDLE) begin
			count <= '0;
			part_rem <= '0;
			dividend_sr <= req.dividend_mag; // Load on start.
		end else begin
			quot_sr <= {quot_sr[`DIV_XLEN-2:0], ge};
			dividend_sr <= {dividend_sr[`DIV_XLEN-2:0], 1'b0};
			if (count != CNT_W'(`DIV_XLEN)) begin
				count <= count + 1'b1;
				part_rem <= {rem_sel[`DIV_XLEN-1:0], dividend_sr[`DIV_XLEN-1]};
			end else begin
				part_rem <= rem_sel; // Final correction, no shift.
			end
		end
	end

	assign rsp = '{
		quotient: quot_sr,
		remainder: part_rem[`DIV_XLEN-1:0],
		by_zero: by_zero_q
	};

endmodule

/* logic/div_bus_decode.sv */
`timescale 1ns/1ps
`include "div_config.svh"

module div_bus_decode (
	input  logic              clk,
	input  logic              rst_n,
	input  div_pkg::wb_m2s_s  bus_in,
	output div_pkg::wb_s2m_s  bus_out,
	input  logic              result_valid,
	input  div_pkg::word_t    quotient,
	input  div_pkg::word_t    remainder,
	input  logic              by_zero,
	output logic              start,
	output div_pkg::div_req_s req
);

	div_pkg::word_t   dividend_q; // Operand registers.
	div_pkg::word_t   divisor_q;
	div_pkg::div_op_e op_q; // Last op written.
	div_pkg::div_op_e new_op; // Op on the bus.
	div_pkg::word_t   rdata; // Read mux.
	div_pkg::word_t   dat_q;
	logic             ack_q;
	logic             busy;
	logic             access; // Open cycle, not yet acked.
	logic             result_reg; // Addresses that wait on busy.
	logic             stall;
	logic             wr;
	logic             rd;
	logic             is_signed;
	logic             dividend_neg;
	logic             divisor_neg;

	// ------------------------------------------------------------------
	// Address decode and wait states
	// ------------------------------------------------------------------
	assign access = bus_in.cyc && bus_in.stb && !ack_q; // One ack per access.
	assign result_reg = (bus_in.adr == `DIV_REG_CTRL) || (bus_in.adr == `DIV_REG_QUOT) ||
		(bus_in.adr == `DIV_REG_REM);
	assign stall = busy && result_reg; // Hold until result stored.
	assign wr = access && !stall && bus_in.we;
	assign rd = access && !stall && !bus_in.we;

	assign new_op = div_pkg::div_op_e'(bus_in.dat[1:0]);
	assign is_signed = new_op inside {div_pkg::DIV, div_pkg::REM};
	assign dividend_neg = is_signed && dividend_q[`DIV_XLEN-1];
	assign divisor_neg = is_signed && divisor_q[`DIV_XLEN-1];

	always_comb begin
		rdata = '0;
		case (bus_in.adr)
			`DIV_REG_DIVIDEND: rdata = dividend_q;
			`DIV_REG_DIVISOR: rdata = divisor_q;
			`DIV_REG_CTRL: rdata[3:0] = {op_q, by_zero, busy}; // Status word.
			`DIV_REG_QUOT: rdata = quotient;
			`DIV_REG_REM: rdata = remainder;
			default: rdata = '0; // Unmapped reads as zero.
		endcase
	end

	// ------------------------------------------------------------------
	// Control state
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			busy <= 1'b0;
			start <= 1'b0;
			op_q <= div_pkg::DIVU;
		end else begin
			ack_q <= access && !stall;
			start <= 1'b0;
			if (result_valid)
				busy <= 1'b0; // Result registers valid now.
			if (wr && bus_in.adr == `DIV_REG_CTRL) begin
				busy <= 1'b1;
				start <= 1'b1;
				op_q <= new_op;
			end
		end
	end

	// Operands, request and read data.
	always_ff @(posedge clk) begin
		if (wr && bus_in.adr == `DIV_REG_DIVIDEND)
			dividend_q <= bus_in.dat;
		if (wr && bus_in.adr == `DIV_REG_DIVISOR)
			divisor_q <= bus_in.dat;
		if (wr && bus_in.adr == `DIV_REG_CTRL) begin
			req.dividend_mag <= dividend_neg ? -dividend_q : dividend_q;
			req.divisor_mag <= divisor_neg ? -divisor_q : divisor_q;
			req.neg_quot <= dividend_neg ^ divisor_neg; // Signs differ.
			req.neg_rem <= dividend_neg; // Remainder follows dividend.
			req.dividend <= dividend_q;
		end
		if (rd)
			dat_q <= rdata;
	end

	assign bus_out = '{ack: ack_q, dat: dat_q};

endmodule

/* logic/div_pkg.sv */
`include "div_config.svh"

package div_pkg;

	typedef logic [`DIV_XLEN-1:0] word_t; // Operand or result word.
	typedef logic [`DIV_ADR_W-1:0] wb_adr_t; // Bus word address.

	// Bit 0 marks the signed ops.
	typedef enum logic [1:0] {
		DIVU = 2'd0,
		DIV  = 2'd1,
		REMU = 2'd2,
		REM  = 2'd3
	} div_op_e;

	typedef enum logic {
		CORE_IDLE,
		CORE_SHIFT
	} core_state_e;

	typedef struct packed {
		word_t dividend_mag; // Unsigned magnitude.
		word_t divisor_mag;
		logic  neg_quot; // Negate quotient at fixup.
		logic  neg_rem; // Negate remainder at fixup.
		word_t dividend; // As written, for the by-zero rule.
	} div_req_s;

	typedef struct packed {
		word_t quotient;
		word_t remainder;
		logic  by_zero;
	} div_rsp_s;

	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		word_t   dat;
	} wb_m2s_s;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_s2m_s;

endpackage

/* logic/div_config.svh */
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// Datapath and bus widths ---------------------------------------------
`define DIV_XLEN 32 // Operand and result width.
`define DIV_ADR_W 3 // Wishbone word address width.

// Register map, word addresses ----------------------------------------
`define DIV_REG_DIVIDEND (`DIV_ADR_W'(0)) // Dividend, read/write.
`define DIV_REG_DIVISOR (`DIV_ADR_W'(1)) // Divisor, read/write.
`define DIV_REG_CTRL (`DIV_ADR_W'(2)) // Op code on write, status on read.
`define DIV_REG_QUOT (`DIV_ADR_W'(3)) // Quotient, read only.
`define DIV_REG_REM (`DIV_ADR_W'(4)) // Remainder, read only.

`endif
